// ==== logic/etx_settings.svh ====
`ifndef ETX_SETTINGS_SVH
`define ETX_SETTINGS_SVH

// ####################################################################
// Transmit queue sizing
// ####################################################################

// Entries per channel queue
// Also the credit count the fabric starts with
`define ETX_FIFO_DEPTH 4

// Occupancy counter width, one more bit than the pointers
// so that a full queue can be told apart from an empty one
`define ETX_CNT_W ($clog2(`ETX_FIFO_DEPTH) + 1)

`endif

// ==== logic/etx_pkg.sv ====
package etx_pkg;

   // ####################################################################
   // Packet field types
   // ####################################################################

   // Destination and source address
   typedef logic [31:0] addr_t;

   // Write data payload
   typedef logic [31:0] data_t;

   // Control mode nibble
   typedef logic [3:0] ctrlmode_t;

   // Transfer size, byte to double
   typedef logic [1:0] datamode_t;

   // Fabric packet, 103 bits
   // Field order matches the eMesh packet from msb down
   typedef struct packed {
      logic      write;
      datamode_t datamode;
      ctrlmode_t ctrlmode;
      addr_t     dstaddr;
      data_t     data;
      addr_t     srcaddr;
   } emesh_packet_t;

   // One link word, sent per clock
   typedef logic [15:0] link_word_t;

   // ####################################################################
   // State encodings
   // ####################################################################

   // Transmit frame sequencer, one state per link word
   typedef enum logic [2:0] {
      IDLE   = 3'd0,
      CYCLE1 = 3'd1,
      CYCLE2 = 3'd2,
      CYCLE3 = 3'd3,
      CYCLE4 = 3'd4,
      CYCLE5 = 3'd5,
      CYCLE6 = 3'd6,
      CYCLE7 = 3'd7
   } tx_state_t;

   // Request channel, for grant and priority pointer
   typedef enum logic {
      CH_WR = 1'b0,
      CH_RD = 1'b1
   } chan_t;

endpackage

// ==== logic/etx_fifo.sv ====
`include "etx_settings.svh"

module etx_fifo (
   input  logic                   tx_lclk_io,
   input  logic                   nreset,
   input  etx_pkg::emesh_packet_t pkt,
   input  logic                   valid,
   input  logic                   pop,
   output etx_pkg::emesh_packet_t head,
   output logic                   not_empty,
   output logic                   credit
);

   import etx_pkg::*;

   // Pointer and counter types
   typedef logic [`ETX_CNT_W-2:0] ptr_t;
   typedef logic [`ETX_CNT_W-1:0] cnt_t;

   // Last slot index, pointers wrap here
   localparam ptr_t PTR_LAST = ptr_t'(`ETX_FIFO_DEPTH - 1);
   // Count seen when every slot is taken
   localparam cnt_t CNT_FULL = cnt_t'(`ETX_FIFO_DEPTH);

   // Packet storage
   emesh_packet_t mem [`ETX_FIFO_DEPTH];

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   cnt_t count;

   // ####################################################################
   // Storage write
   // ####################################################################

   always_ff @(posedge tx_lclk_io)
   begin
      if (valid)
         mem[wr_ptr] <= pkt;
   end

   // ####################################################################
   // Pointers, occupancy and credit return
   // ####################################################################

   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end
      else
      begin
         // Circular advance on push
         if (valid)
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + ptr_t'(1);
         // Circular advance on pop
         if (pop)
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + ptr_t'(1);
         // Simultaneous push and pop leave count alone
         if (valid && !pop)
            count <= count + cnt_t'(1);
         else if (pop && !valid)
            count <= count - cnt_t'(1);
         // One credit per released entry, a cycle late
         credit <= pop;
      end
   end

   // Oldest entry straight from storage
   assign head      = mem[rd_ptr];
   assign not_empty = (count != '0);

   // Fabric must stay within its credits
   a_no_push_full: assert property (@(posedge tx_lclk_io) disable iff (!nreset)
      valid |-> (count != CNT_FULL));

   // Arbiter pops only a queue it saw non-empty
   a_no_pop_empty: assert property (@(posedge tx_lclk_io) disable iff (!nreset)
      pop |-> not_empty);

endmodule

// ==== logic/etx_arbiter.sv ====
module etx_arbiter (
   input  logic                   tx_lclk_io,
   input  logic                   nreset,
   input  logic                   wr_not_empty,
   input  logic                   rd_not_empty,
   input  etx_pkg::emesh_packet_t wr_head,
   input  etx_pkg::emesh_packet_t rd_head,
   input  logic                   wr_wait,
   input  logic                   rd_wait,
   input  logic                   idle,
   output logic                   wr_pop,
   output logic                   rd_pop,
   output logic                   access,
   output etx_pkg::emesh_packet_t packet
);

   import etx_pkg::*;

   // Registered link back-pressure
   logic  wr_wait_q;
   logic  rd_wait_q;
   // Channel may be granted
   logic  wr_elig;
   logic  rd_elig;
   logic  grant_valid;
   chan_t grant;
   // Channel favored on a tie
   chan_t rr_ptr;

   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         wr_wait_q <= 1'b0;
         rd_wait_q <= 1'b0;
      end
      else
      begin
         wr_wait_q <= wr_wait;
         rd_wait_q <= rd_wait;
      end
   end

   assign wr_elig = wr_not_empty && !wr_wait_q;
   assign rd_elig = rd_not_empty && !rd_wait_q;

   // ####################################################################
   // Round-robin grant
   // ####################################################################

   always_comb
   begin
      // Skip the cycle right after an access, idle is still stale then
      grant_valid = idle && !access && (wr_elig || rd_elig);
      if (wr_elig && rd_elig)
         grant = rr_ptr;
      else if (rd_elig)
         grant = CH_RD;
      else
         grant = CH_WR;
   end

   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         access <= 1'b0;
         wr_pop <= 1'b0;
         rd_pop <= 1'b0;
         rr_ptr <= CH_WR;
      end
      else
      begin
         access <= grant_valid;
         wr_pop <= grant_valid && (grant == CH_WR);
         rd_pop <= grant_valid && (grant == CH_RD);
         // Hand priority to the loser
         if (grant_valid)
            rr_ptr <= (grant == CH_WR) ? CH_RD : CH_WR;
      end
   end

   // Head captured alongside access, popped entry is the same one
   always_ff @(posedge tx_lclk_io)
   begin
      if (grant_valid)
         packet <= (grant == CH_WR) ? wr_head : rd_head;
   end

   // One queue released per grant
   a_one_pop: assert property (@(posedge tx_lclk_io) disable iff (!nreset)
      !(wr_pop && rd_pop));

endmodule

// ==== logic/etx_serializer.sv ====
module etx_serializer (
   input  logic                   tx_lclk_io,
   input  logic                   nreset,
   input  logic                   access,
   input  etx_pkg::emesh_packet_t packet,
   output logic                   idle,
   output logic                   tx_frame,
   output etx_pkg::link_word_t    tx_data
);

   import etx_pkg::*;

   tx_state_t     tx_state;
   // State delayed one cycle, lines up with staging contents
   tx_state_t     tx_state_reg;
   // Packet held for the whole frame
   emesh_packet_t tx_packet_reg;
   // Staging, header first then data and source address
   logic [63:0]   tx_double;

   // ####################################################################
   // Frame sequencer
   // ####################################################################

   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
         tx_state <= IDLE;
      else
      begin
         case (tx_state)
            IDLE   : tx_state <= access ? CYCLE1 : IDLE;
            CYCLE1 : tx_state <= CYCLE2;
            CYCLE2 : tx_state <= CYCLE3;
            CYCLE3 : tx_state <= CYCLE4;
            CYCLE4 : tx_state <= CYCLE5;
            CYCLE5 : tx_state <= CYCLE6;
            CYCLE6 : tx_state <= CYCLE7;
            // No burst, always back to idle
            CYCLE7 : tx_state <= IDLE;
            default: tx_state <= IDLE;
         endcase
      end
   end

   // Ready for the next packet
   assign idle = (tx_state == IDLE);

   // ####################################################################
   // Packet capture and staging
   // ####################################################################

   always_ff @(posedge tx_lclk_io)
   begin
      if (access)
         tx_packet_reg <= packet;
   end

   // Header loads at CYCLE1, data half loads at CYCLE4
   // Header word 1 sits in bits 47:32, upper 16 unused
   always_ff @(posedge tx_lclk_io)
   begin
      if (tx_state == CYCLE1)
         tx_double <= {16'b0,
                       ~tx_packet_reg.write,
                       7'b0,
                       tx_packet_reg.ctrlmode,
                       tx_packet_reg.dstaddr,
                       tx_packet_reg.datamode,
                       tx_packet_reg.write,
                       1'b1};
      else if (tx_state == CYCLE4)
         tx_double <= {tx_packet_reg.data, tx_packet_reg.srcaddr};
   end

   // ####################################################################
   // Link word output
   // ####################################################################

   always_ff @(posedge tx_lclk_io)
   begin
      if (!nreset)
      begin
         tx_state_reg <= IDLE;
         tx_frame     <= 1'b0;
         tx_data      <= '0;
      end
      else
      begin
         tx_state_reg <= tx_state;
         // Frame high for every non-idle delayed state
         tx_frame     <= (tx_state_reg != IDLE);
         case (tx_state_reg)
            // Header words
            CYCLE1 : tx_data <= tx_double[47:32];
            CYCLE2 : tx_data <= tx_double[31:16];
            CYCLE3 : tx_data <= tx_double[15:0];
            // Data words
            CYCLE4 : tx_data <= tx_double[63:48];
            CYCLE5 : tx_data <= tx_double[47:32];
            // Source address words
            CYCLE6 : tx_data <= tx_double[31:16];
            CYCLE7 : tx_data <= tx_double[15:0];
            // Quiet link between frames
            default: tx_data <= '0;
         endcase
      end
   end

   // Arbiter only starts a frame on an idle sequencer
   a_access_idle: assert property (@(posedge tx_lclk_io) disable iff (!nreset)
      access |-> (tx_state == IDLE));

endmodule

// ==== logic/etx_top.sv ====
module etx_top (
   input  logic                   tx_lclk_io,
   input  logic                   nreset,
   input  etx_pkg::emesh_packet_t wr_pkt,
   input  logic                   wr_valid,
   input  etx_pkg::emesh_packet_t rd_pkt,
   input  logic                   rd_valid,
   input  logic                   wr_wait,
   input  logic                   rd_wait,
   output logic                   wr_credit,
   output logic                   rd_credit,
   output logic                   tx_frame,
   output etx_pkg::link_word_t    tx_data
);

   import etx_pkg::*;

   // Queue heads toward the arbiter
   emesh_packet_t wr_head;
   emesh_packet_t rd_head;
   logic          wr_not_empty;
   logic          rd_not_empty;
   logic          wr_pop;
   logic          rd_pop;
   // Arbiter to serializer handoff
   emesh_packet_t arb_packet;
   logic          arb_access;
   logic          ser_idle;

   // ####################################################################
   // Channel queues
   // ####################################################################

   // Write requests
   etx_fifo u_wr_fifo (
      .tx_lclk_io (tx_lclk_io),
      .nreset     (nreset),
      .pkt        (wr_pkt),
      .valid      (wr_valid),
      .pop        (wr_pop),
      .head       (wr_head),
      .not_empty  (wr_not_empty),
      .credit     (wr_credit)
   );

   // Read requests
   etx_fifo u_rd_fifo (
      .tx_lclk_io (tx_lclk_io),
      .nreset     (nreset),
      .pkt        (rd_pkt),
      .valid      (rd_valid),
      .pop        (rd_pop),
      .head       (rd_head),
      .not_empty  (rd_not_empty),
      .credit     (rd_credit)
   );

   // ####################################################################
   // Arbitration and link transmit
   // ####################################################################

   etx_arbiter u_arbiter (
      .tx_lclk_io   (tx_lclk_io),
      .nreset       (nreset),
      .wr_not_empty (wr_not_empty),
      .rd_not_empty (rd_not_empty),
      .wr_head      (wr_head),
      .rd_head      (rd_head),
      .wr_wait      (wr_wait),
      .rd_wait      (rd_wait),
      .idle         (ser_idle),
      .wr_pop       (wr_pop),
      .rd_pop       (rd_pop),
      .access       (arb_access),
      .packet       (arb_packet)
   );

   etx_serializer u_serializer (
      .tx_lclk_io (tx_lclk_io),
      .nreset     (nreset),
      .access     (arb_access),
      .packet     (arb_packet),
      .idle       (ser_idle),
      .tx_frame   (tx_frame),
      .tx_data    (tx_data)
   );

endmodule

// ==== sim/etx_checker.sv ====
module etx_checker (
   input  logic                   tx_lclk_io,
   input  logic                   nreset,
   input  etx_pkg::emesh_packet_t wr_pkt,
   input  logic                   wr_valid,
   input  etx_pkg::emesh_packet_t rd_pkt,
   input  logic                   rd_valid,
   input  logic                   wr_credit,
   input  logic                   rd_credit,
   input  logic                   tx_frame,
   input  etx_pkg::link_word_t    tx_data,
   output logic                   err,
   output int                     frames,
   output int                     pending
);

   timeunit 1ns;
   timeprecision 100ps;

   import etx_pkg::*;

   // Expected packets per channel, push order
   emesh_packet_t wr_q[$];
   emesh_packet_t rd_q[$];
   // Words of the frame being collected
   link_word_t    words[7];
   int            word_idx = 0;
   logic          pushed_any = 1'b0;
   // Outputs hold their reset values from the second reset edge on
   logic          reset_seen = 1'b0;
   emesh_packet_t got_pkt;
   emesh_packet_t exp_pkt;

   initial
   begin
      err     = 1'b0;
      frames  = 0;
      pending = 0;
   end

   task automatic compare_packet(input string name, input emesh_packet_t got,
                                 input emesh_packet_t exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         err = 1'b1;
      end
   endtask

   task automatic compare_word(input string name, input link_word_t got,
                               input link_word_t exp);
      if (got !== exp)
      begin
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         err = 1'b1;
      end
   endtask

   task automatic report(input string msg);
      $display("%s", msg);
      err = 1'b1;
   endtask

   // Link word i of a frame, straight from the frame format
   function automatic link_word_t frame_word(input emesh_packet_t p, input int i);
      case (i)
         0: return {~p.write, 7'b0, p.ctrlmode, p.dstaddr[31:28]};
         1: return p.dstaddr[27:12];
         2: return {p.dstaddr[11:0], p.datamode, p.write, 1'b1};
         3: return p.data[31:16];
         4: return p.data[15:0];
         5: return p.srcaddr[31:16];
         default: return p.srcaddr[15:0];
      endcase
   endfunction

   // ####################################################################
   // Fabric side snoop and link side decode
   // ####################################################################

   always @(posedge tx_lclk_io)
   begin
      // Quiet link and no credits before any traffic
      if (!pushed_any && reset_seen)
      begin
         if (tx_frame !== 1'b0)
            report("tx_frame went high before any packet was pushed");
         compare_word("tx_data", tx_data, '0);
         if (wr_credit !== 1'b0 || rd_credit !== 1'b0)
            report("A credit was returned before any packet was pushed");
      end
      if (nreset)
      begin
         if (wr_valid)
         begin
            wr_q.push_back(wr_pkt);
            pushed_any = 1'b1;
         end
         if (rd_valid)
         begin
            rd_q.push_back(rd_pkt);
            pushed_any = 1'b1;
         end
         if (tx_frame)
         begin
            if (word_idx >= 7)
               report("Frame ran longer than seven words");
            else
               words[word_idx] = tx_data;
            word_idx++;
         end
         else
         begin
            compare_word("tx_data", tx_data, '0);
            if (word_idx != 0 && word_idx != 7)
               report("Frame ended with the wrong number of words");
            else if (word_idx == 7)
            begin
               // Rebuild fields from their frame positions
               got_pkt.write    = words[2][1];
               got_pkt.datamode = words[2][3:2];
               got_pkt.ctrlmode = words[0][7:4];
               got_pkt.dstaddr  = {words[0][3:0], words[1], words[2][15:4]};
               got_pkt.data     = {words[3], words[4]};
               got_pkt.srcaddr  = {words[5], words[6]};
               if (got_pkt.write ? wr_q.size() == 0 : rd_q.size() == 0)
                  report("Frame arrived with no pending packet on its channel");
               else
               begin
                  exp_pkt = got_pkt.write ? wr_q.pop_front() : rd_q.pop_front();
                  compare_packet("packet", got_pkt, exp_pkt);
                  for (int i = 0; i < 7; i++)
                     compare_word("tx_data", words[i], frame_word(exp_pkt, i));
               end
               frames++;
            end
            word_idx = 0;
         end
      end
      pending = wr_q.size() + rd_q.size();
      if (!nreset)
         reset_seen = 1'b1;
   end

endmodule

// ==== sim/etx_tb.sv ====
`include "etx_settings.svh"

module etx_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import etx_pkg::*;

   localparam int N_PKT = 200;
   // Frames, gaps and wait phases fit well inside this
   localparam int LIMIT = N_PKT * 10 + 1000;

   logic          tx_lclk_io = 1'b0;
   logic          nreset;
   emesh_packet_t wr_pkt;
   emesh_packet_t rd_pkt;
   logic          wr_valid;
   logic          rd_valid;
   logic          wr_wait;
   logic          rd_wait;
   logic          wr_credit;
   logic          rd_credit;
   logic          tx_frame;
   link_word_t    tx_data;
   logic          chk_err;
   int            chk_frames;
   int            chk_pending;

   int   seed;
   int   cycle = 0;
   int   wr_cred = `ETX_FIFO_DEPTH;
   int   rd_cred = `ETX_FIFO_DEPTH;
   int   wr_left = N_PKT / 2;
   int   rd_left = N_PKT / 2;
   logic frame_q = 1'b0;
   logic wr_wait_q = 1'b0;
   logic rd_wait_q = 1'b0;
   int   wr_wait_rise = 0;
   int   rd_wait_rise = 0;
   // Frames of the other channel during each wait phase
   int   rd_in_wwait = 0;
   int   wr_in_rwait = 0;
   // Round-robin phase bookkeeping
   logic rr_phase = 1'b0;
   int   rr_start = 0;
   int   rr_count = 0;
   logic rr_last_wr = 1'b0;
   logic start_wr;

   etx_top UUT (.*);

   etx_checker u_checker (
      .tx_lclk_io (tx_lclk_io), .nreset (nreset),
      .wr_pkt (wr_pkt), .wr_valid (wr_valid), .rd_pkt (rd_pkt), .rd_valid (rd_valid),
      .wr_credit (wr_credit), .rd_credit (rd_credit),
      .tx_frame (tx_frame), .tx_data (tx_data),
      .err (chk_err), .frames (chk_frames), .pending (chk_pending)
   );

   always #10 tx_lclk_io = ~tx_lclk_io;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   // Checker mismatch ends the run
   always @(posedge chk_err)
   begin
      $display("Test FAILED");
      $fatal(1);
   end

   task automatic make_packet(input logic wr, output emesh_packet_t p);
      int r;
      r          = $random(seed);
      p.write    = wr;
      p.datamode = r[1:0];
      p.ctrlmode = r[7:4];
      p.dstaddr  = $random(seed);
      p.data     = $random(seed);
      p.srcaddr  = $random(seed);
   endtask

   // One cycle of stimulus, pushes only while credit is held
   task automatic step(input int pct, input logic wwait, input logic rwait);
      int roll;
      @(posedge tx_lclk_io);
      #2;
      wr_wait  = wwait;
      rd_wait  = rwait;
      wr_valid = 1'b0;
      rd_valid = 1'b0;
      roll = ($random(seed) & 32'h7fff_ffff) % 100;
      if (wr_left > 0 && wr_cred > 0 && roll < pct)
      begin
         make_packet(1'b1, wr_pkt);
         wr_valid = 1'b1;
         wr_left--;
      end
      roll = ($random(seed) & 32'h7fff_ffff) % 100;
      if (rd_left > 0 && rd_cred > 0 && roll < pct)
      begin
         make_packet(1'b0, rd_pkt);
         rd_valid = 1'b1;
         rd_left--;
      end
   endtask

   // ####################################################################
   // Sampling monitor: credits, wait honoring, alternation, timeout
   // ####################################################################

   always @(posedge tx_lclk_io)
   begin
      cycle++;
      if (cycle >= LIMIT)
         fail_run("Timeout: not every packet was framed within the cycle limit");
      if (nreset)
      begin
         wr_cred = wr_cred - (wr_valid ? 1 : 0) + (wr_credit ? 1 : 0);
         rd_cred = rd_cred - (rd_valid ? 1 : 0) + (rd_credit ? 1 : 0);
         if (wr_cred < 0 || wr_cred > `ETX_FIFO_DEPTH || rd_cred < 0
             || rd_cred > `ETX_FIFO_DEPTH)
            fail_run("A channel's credit count left its legal range");
         if (wr_wait && !wr_wait_q)
            wr_wait_rise = cycle;
         if (rd_wait && !rd_wait_q)
            rd_wait_rise = cycle;
         wr_wait_q = wr_wait;
         rd_wait_q = rd_wait;
         // Rising frame, word 1 msb is the inverted write bit
         if (tx_frame && !frame_q)
         begin
            start_wr = !tx_data[15];
            if (start_wr && wr_wait && cycle > wr_wait_rise + 5)
               fail_run("A write frame began while wr_wait was high");
            if (!start_wr && rd_wait && cycle > rd_wait_rise + 5)
               fail_run("A read frame began while rd_wait was high");
            if (wr_wait && !start_wr)
               rd_in_wwait++;
            if (rd_wait && start_wr)
               wr_in_rwait++;
            if (rr_phase && cycle >= rr_start + 8)
            begin
               if (rr_count > 0 && start_wr == rr_last_wr)
                  fail_run("Saturated channels did not alternate on the link");
               rr_count++;
               rr_last_wr = start_wr;
            end
         end
         frame_q = tx_frame;
      end
   end

   // ####################################################################
   // Test sequence
   // ####################################################################

   initial
   begin
      seed     = 32'h9474;
      nreset   = 1'b0;
      wr_pkt   = '0;
      rd_pkt   = '0;
      wr_valid = 1'b0;
      rd_valid = 1'b0;
      wr_wait  = 1'b0;
      rd_wait  = 1'b0;
      repeat (3) @(posedge tx_lclk_io);
      #2 nreset = 1'b1;
      // Quiet link for a few cycles after reset
      repeat (4) step(0, 1'b0, 1'b0);
      while (wr_left + rd_left > N_PKT - 40)
         step(50, 1'b0, 1'b0);
      // Write channel stalled
      repeat (60) step(50, 1'b1, 1'b0);
      if (rd_in_wwait == 0)
         fail_run("No read frame was sent while the write channel waited");
      // Read channel stalled
      repeat (60) step(50, 1'b0, 1'b1);
      if (wr_in_rwait == 0)
         fail_run("No write frame was sent while the read channel waited");
      // Both channels saturated
      rr_start = cycle;
      rr_phase = 1'b1;
      repeat (150) step(100, 1'b0, 1'b0);
      rr_phase = 1'b0;
      if (rr_count < 4)
         fail_run("Too few frames were seen in the saturated phase");
      while (wr_left > 0 || rd_left > 0)
         step(50, 1'b0, 1'b0);
      while (chk_frames < N_PKT)
         step(0, 1'b0, 1'b0);
      // Last credits come back a cycle after their pops
      repeat (4) step(0, 1'b0, 1'b0);
      if (chk_pending != 0)
         fail_run("Packets were left in the expected queues");
      else if (wr_cred != `ETX_FIFO_DEPTH || rd_cred != `ETX_FIFO_DEPTH)
         fail_run("Credits did not all return to the fabric");
      else
      begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

// ==== files.f ====
+incdir+logic
logic/etx_pkg.sv
logic/etx_fifo.sv
logic/etx_arbiter.sv
logic/etx_serializer.sv
logic/etx_top.sv
sim/etx_checker.sv
sim/etx_tb.sv

// ==== Makefile ====
# Verilator flow for the eLink transmit subsystem

TOP := etx_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f files.f --top-module $(TOP)
	verilator --lint-only -Wall -f files.f logic/etx_top.sv --top-module etx_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TOP) -o etx_sim
	./obj_dir/etx_sim 2>&1 | tee $(LOG)
	@if grep -q "Test OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
